// ==== compile.f ====
+incdir+include
rtl/exu_pkg.sv
rtl/exu_alu.sv
rtl/exu_csr_file.sv
rtl/exu_stage.sv
rtl/exu_data_ram.sv
rtl/exu_top.sv
dv/exu_tb.sv

// ==== dv/exu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exu_macros.svh"

module exu_tb;
  import exu_pkg::*;

  localparam int XLEN          = `EXU_XLEN;
  localparam int AW            = $clog2(`EXU_RAM_WORDS);
  localparam int CLK_HALF      = 20;
  localparam int RST_CYCLES    = 8;
  localparam int CYCLES_PER_OP = 40;
  localparam int MIE_BIT       = 3;
  localparam int MPIE_BIT      = 7;

  typedef struct packed {
    logic [31:0]     inst;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] opj;
    logic [3:0]      alu_op;
    logic [3:0]      rd;
    logic            ren;
    logic            wen;
    logic            sys;
    logic            csr_wen;
    logic [XLEN-1:0] exp_wdata;
    logic            exp_redir;
    logic [XLEN-1:0] exp_npc;
  } op_t;

  logic            clk;
  logic            rst;
  logic [31:0]     inst_i;
  logic [XLEN-1:0] pc_i;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] op1_i;
  logic [XLEN-1:0] op2_i;
  logic [XLEN-1:0] opj_i;
  alu_op_e         alu_op_i;
  logic [3:0]      rd_i;
  logic            ren_i;
  logic            wen_i;
  logic            system_i;
  logic            csr_wen_i;
  logic            prev_valid_i;
  logic            ready_o;
  logic            valid_o;
  logic            next_ready_i;
  logic [3:0]      rd_o;
  logic [XLEN-1:0] reg_wdata_o;
  logic [XLEN-1:0] npc_o;
  logic            redirect_o;

  op_t             table_q[$];
  logic            table_ready = 1'b0;
  int              cur_entry   = 0;
  logic [31:0]     rand_state  = 32'hf8e9_eb72;

  // reference state
  logic [XLEN-1:0] model_mem [`EXU_RAM_WORDS];
  logic [XLEN-1:0] model_mstatus = `EXU_MSTATUS_RST;
  logic [XLEN-1:0] model_mepc    = '0;
  logic [XLEN-1:0] model_mcause  = '0;
  logic [XLEN-1:0] model_mtvec   = '0;

  exu_top exu_top_inst (
    .clk          (clk),
    .rst          (rst),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .imm_i        (imm_i),
    .op1_i        (op1_i),
    .op2_i        (op2_i),
    .opj_i        (opj_i),
    .alu_op_i     (alu_op_i),
    .rd_i         (rd_i),
    .ren_i        (ren_i),
    .wen_i        (wen_i),
    .system_i     (system_i),
    .csr_wen_i    (csr_wen_i),
    .prev_valid_i (prev_valid_i),
    .ready_o      (ready_o),
    .valid_o      (valid_o),
    .next_ready_i (next_ready_i),
    .rd_o         (rd_o),
    .reg_wdata_o  (reg_wdata_o),
    .npc_o        (npc_o),
    .redirect_o   (redirect_o)
  );

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  task automatic check_value(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s at entry %0d: got 0x%h, expected 0x%h", name, cur_entry, got, exp);
      $display("Regression failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  function automatic logic [XLEN-1:0] read_model_csr(logic [11:0] addr);
    case (addr)
      CSR_MSTATUS: return model_mstatus;
      CSR_MTVEC:   return model_mtvec;
      CSR_MEPC:    return model_mepc;
      CSR_MCAUSE:  return model_mcause;
      default:     return '0;
    endcase
  endfunction

  task automatic write_model_csr(logic [11:0] addr, logic [XLEN-1:0] val);
    case (addr)
      CSR_MSTATUS: model_mstatus = val;
      CSR_MTVEC:   model_mtvec   = val;
      CSR_MEPC:    model_mepc    = val;
      CSR_MCAUSE:  model_mcause  = val;
      default: begin
      end
    endcase
  endtask

  task automatic add_op(opcode_e opc, logic [2:0] f3, alu_op_e op, logic [XLEN-1:0] pc,
                        logic [XLEN-1:0] imm, logic [XLEN-1:0] op1, logic [XLEN-1:0] op2,
                        logic [XLEN-1:0] opj, logic [3:0] rd, logic [XLEN-1:0] exp_wdata,
                        logic exp_redir);
    op_t e;
    e           = '0;
    e.inst      = {17'd0, f3, 5'd0, opc};
    e.pc        = pc;
    e.imm       = imm;
    e.op1       = op1;
    e.op2       = op2;
    e.opj       = opj;
    e.alu_op    = op;
    e.rd        = rd;
    e.ren       = (opc == OP_LOAD);
    e.wen       = (opc == OP_STORE);
    e.sys       = (opc == OP_SYSTEM);
    e.csr_wen   = e.sys && (f3 != 3'd0);
    e.exp_wdata = exp_wdata;
    e.exp_redir = exp_redir;
    // jump base plus immediate unless ecall or mret replace it
    e.exp_npc   = opj + imm;
    table_q.push_back(e);
  endtask

  // fills in the memory and CSR results in program order
  task automatic predict(inout op_t e);
    logic [XLEN-1:0] addr;
    logic [AW-1:0]   idx;
    logic [XLEN-1:0] old;
    logic [2:0]      f3;
    addr = e.opj + e.imm;
    idx  = addr[AW+1:2];
    f3   = e.inst[14:12];
    old  = read_model_csr(e.imm[11:0]);
    if (e.wen) begin
      model_mem[idx] = e.op2;
    end else if (e.ren) begin
      e.exp_wdata = model_mem[idx];
    end else if (e.sys && (f3 == 3'd0)) begin
      e.exp_wdata = old;
      e.exp_redir = 1'b1;
      if (e.imm[11:0] == 12'h000) begin
        e.exp_npc               = model_mtvec;
        model_mepc              = e.pc;
        model_mcause            = 32'd11;
        model_mstatus[MPIE_BIT] = model_mstatus[MIE_BIT];
        model_mstatus[MIE_BIT]  = 1'b0;
      end else begin
        e.exp_npc               = model_mepc;
        model_mstatus[MIE_BIT]  = model_mstatus[MPIE_BIT];
        model_mstatus[MPIE_BIT] = 1'b1;
      end
    end else if (e.sys) begin
      e.exp_wdata = old;
      case (f3[1:0])
        2'b01:   write_model_csr(e.imm[11:0], e.op1);
        2'b10:   write_model_csr(e.imm[11:0], old | e.op1);
        default: write_model_csr(e.imm[11:0], old & ~e.op1);
      endcase
    end
    if (e.rd == 4'd0) begin
      e.exp_wdata = '0;
    end
  endtask

  task automatic build_table();
    // opcode, funct3, alu op, pc, imm, op1, op2, opj, rd, wdata, redirect
    add_op(OP_ALU, 0, ADD, 'h0, 'h0, 'h5, 'h7, 'h0, 1, 'hc, 0);
    add_op(OP_ALU, 0, SUB, 'h0, 'h0, 'h3, 'h5, 'h0, 2, 'hfffffffe, 0);
    add_op(OP_ALU, 0, AND, 'h0, 'h0, 'hf0f0f0f0, 'hff00ff00, 'h0, 3, 'hf000f000, 0);
    add_op(OP_ALU, 0, OR, 'h0, 'h0, 'hf0f00000, 'h00000f0f, 'h0, 4, 'hf0f00f0f, 0);
    add_op(OP_ALU, 0, XOR, 'h0, 'h0, 'haaaa5555, 'hffff0000, 'h0, 5, 'h55555555, 0);
    add_op(OP_ALUI, 0, SLL, 'h0, 'h0, 'h1, 'h21, 'h0, 6, 'h2, 0);
    add_op(OP_ALUI, 0, SRL, 'h0, 'h0, 'h80000000, 'h4, 'h0, 7, 'h08000000, 0);
    add_op(OP_ALUI, 0, SRA, 'h0, 'h0, 'h80000000, 'h4, 'h0, 8, 'hf8000000, 0);
    add_op(OP_ALU, 0, SLT, 'h0, 'h0, 'hffffffff, 'h1, 'h0, 9, 'h1, 0);
    add_op(OP_ALU, 0, SLTU, 'h0, 'h0, 'hffffffff, 'h1, 'h0, 10, 'h0, 0);
    add_op(OP_LUI, 0, PASS2, 'h0, 'h0, 'h0, 'h12345000, 'h0, 11, 'h12345000, 0);
    add_op(OP_AUIPC, 0, ADD, 'h100, 'h0, 'h100, 'h2000, 'h0, 12, 'h2100, 0);
    add_op(OP_ALU, 0, ADD, 'h0, 'h0, 'h5, 'h7, 'h0, 0, 'h0, 0);
    // branches with opj carrying the pc
    add_op(OP_BRANCH, 0, SUB, 'h40, 'h10, 'h7, 'h7, 'h40, 0, 'h0, 1);
    add_op(OP_BRANCH, 0, SUB, 'h44, 'h10, 'h7, 'h8, 'h44, 0, 'h0, 0);
    add_op(OP_BRANCH, 0, XOR, 'h60, 'hfffffff0, 'h1, 'h2, 'h60, 0, 'h0, 1);
    add_op(OP_BRANCH, 0, SLT, 'h80, 'h8, 'hfffffff0, 'h3, 'h80, 0, 'h0, 1);
    add_op(OP_BRANCH, 0, SLTU, 'h84, 'h8, 'hfffffff0, 'h3, 'h84, 0, 'h0, 0);
    add_op(OP_BRANCH, 0, SLE, 'h90, 'h20, 'h2, 'h5, 'h90, 0, 'h0, 1);
    add_op(OP_BRANCH, 0, SLEU, 'h94, 'h20, 'h5, 'h2, 'h94, 0, 'h0, 0);
    add_op(OP_JAL, 0, ADD, 'h100, 'h40, 'h0, 'h0, 'h100, 1, 'h104, 1);
    add_op(OP_JALR, 0, ADD, 'h200, 'h10, 'h0, 'h0, 'h1000, 5, 'h204, 1);
    add_op(OP_JAL, 0, ADD, 'h300, 'hfffffe00, 'h0, 'h0, 'h300, 0, 'h0, 1);
    // loads and stores with results from the model
    add_op(OP_STORE, 2, ADD, 'h0, 'h8, 'h100, 'hdeadbeef, 'h100, 0, 'h0, 0);
    add_op(OP_LOAD, 2, ADD, 'h0, 'h8, 'h100, 'h0, 'h100, 3, 'h0, 0);
    add_op(OP_LOAD, 2, ADD, 'h0, 'h0, 'h200, 'h0, 'h200, 4, 'h0, 0);
    add_op(OP_STORE, 2, ADD, 'h0, 'h0, 'h3fc, 'h12345678, 'h3fc, 0, 'h0, 0);
    add_op(OP_LOAD, 2, ADD, 'h0, 'hc, 'h3f0, 'h0, 'h3f0, 6, 'h0, 0);
    add_op(OP_LOAD, 2, ADD, 'h0, 'h8, 'h100, 'h0, 'h100, 0, 'h0, 0);
    // CSR accesses with the address in imm
    add_op(OP_SYSTEM, CSRRW, ADD, 'h0, 'h305, 'h800, 'h0, 'h0, 1, 'h0, 0);
    add_op(OP_SYSTEM, CSRRS, ADD, 'h0, 'h305, 'h0, 'h0, 'h0, 2, 'h0, 0);
    add_op(OP_SYSTEM, CSRRS, ADD, 'h0, 'h300, 'h8, 'h0, 'h0, 3, 'h0, 0);
    add_op(OP_SYSTEM, CSRRS, ADD, 'h0, 'h300, 'h8, 'h0, 'h0, 3, 'h0, 0);
    add_op(OP_SYSTEM, CSRRC, ADD, 'h0, 'h300, 'h1000, 'h0, 'h0, 4, 'h0, 0);
    add_op(OP_SYSTEM, CSRRC, ADD, 'h0, 'h300, 'h1000, 'h0, 'h0, 4, 'h0, 0);
    add_op(OP_SYSTEM, CSRRWI, ADD, 'h0, 'h342, 'h1f, 'h0, 'h0, 5, 'h0, 0);
    add_op(OP_SYSTEM, CSRRCI, ADD, 'h0, 'h342, 'h3, 'h0, 'h0, 6, 'h0, 0);
    add_op(OP_SYSTEM, CSRRSI, ADD, 'h0, 'h342, 'h1, 'h0, 'h0, 7, 'h0, 0);
    add_op(OP_SYSTEM, CSRRS, ADD, 'h0, 'h342, 'h0, 'h0, 'h0, 7, 'h0, 0);
    add_op(OP_SYSTEM, CSRRW, ADD, 'h0, 'h344, 'hffff, 'h0, 'h0, 8, 'h0, 0);
    add_op(OP_SYSTEM, CSRRS, ADD, 'h0, 'h344, 'h0, 'h0, 'h0, 8, 'h0, 0);
    // ecall and a read back of the trap state
    add_op(OP_SYSTEM, PRIV, ADD, 'h400, 'h000, 'h0, 'h0, 'h0, 0, 'h0, 0);
    add_op(OP_SYSTEM, CSRRS, ADD, 'h0, 'h341, 'h0, 'h0, 'h0, 1, 'h0, 0);
    add_op(OP_SYSTEM, CSRRS, ADD, 'h0, 'h342, 'h0, 'h0, 'h0, 2, 'h0, 0);
    add_op(OP_SYSTEM, CSRRS, ADD, 'h0, 'h300, 'h0, 'h0, 'h0, 3, 'h0, 0);
    add_op(OP_SYSTEM, CSRRW, ADD, 'h0, 'h341, 'h500, 'h0, 'h0, 4, 'h0, 0);
    add_op(OP_SYSTEM, PRIV, ADD, 'h900, 'h302, 'h0, 'h0, 'h0, 0, 'h0, 0);
    add_op(OP_SYSTEM, CSRRS, ADD, 'h0, 'h300, 'h0, 'h0, 'h0, 3, 'h0, 0);
  endtask

  task automatic run_op(op_t e);
    logic done;
    inst_i       <= e.inst;
    pc_i         <= e.pc;
    imm_i        <= e.imm;
    op1_i        <= e.op1;
    op2_i        <= e.op2;
    opj_i        <= e.opj;
    alu_op_i     <= alu_op_e'(e.alu_op);
    rd_i         <= e.rd;
    ren_i        <= e.ren;
    wen_i        <= e.wen;
    system_i     <= e.sys;
    csr_wen_i    <= e.csr_wen;
    prev_valid_i <= 1'b1;
    // nothing may be in flight while the op waits to enter
    do begin
      @(posedge clk);
      check_value("valid_o", valid_o, 1'b0);
    end while (!ready_o);
    prev_valid_i <= 1'b0;
    // an outstanding memory access keeps the stage closed
    do begin
      @(posedge clk);
      if (!valid_o) begin
        check_value("ready_o", ready_o, 1'b0);
      end
    end while (!valid_o);
    done = 1'b0;
    // outputs must hold on every stalled cycle
    while (!done) begin
      check_value("valid_o", valid_o, 1'b1);
      check_value("rd_o", rd_o, e.rd);
      check_value("reg_wdata_o", reg_wdata_o, e.exp_wdata);
      check_value("redirect_o", redirect_o, e.exp_redir);
      if (e.exp_redir) begin
        check_value("npc_o", npc_o, e.exp_npc);
      end
      done = next_ready_i;
      if (!done) begin
        @(posedge clk);
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // writeback stalls about a third of the time
  initial begin
    next_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      next_ready_i <= (next_rand() % 3) != 0;
    end
  end

  initial begin
    wait (table_ready);
    repeat (RST_CYCLES + table_q.size() * CYCLES_PER_OP) @(posedge clk);
    $display("Run timed out, the DUT stopped answering at entry %0d", cur_entry);
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    op_t e;
    rst          = 1'b1;
    inst_i       = '0;
    pc_i         = '0;
    imm_i        = '0;
    op1_i        = '0;
    op2_i        = '0;
    opj_i        = '0;
    alu_op_i     = ADD;
    rd_i         = '0;
    ren_i        = 1'b0;
    wen_i        = 1'b0;
    system_i     = 1'b0;
    csr_wen_i    = 1'b0;
    prev_valid_i = 1'b0;
    foreach (model_mem[k]) begin
      model_mem[k] = '0;
    end
    build_table();
    table_ready = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_value("ready_o", ready_o, 1'b1);
    check_value("valid_o", valid_o, 1'b0);
    check_value("redirect_o", redirect_o, 1'b0);
    for (int i = 0; i < table_q.size(); i++) begin
      cur_entry = i;
      e = table_q[i];
      predict(e);
      run_op(e);
    end
    // the last result must leave exactly once
    @(posedge clk);
    check_value("valid_o", valid_o, 1'b0);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== include/exu_macros.svh ====
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// datapath and address width
`define EXU_XLEN 32

// data memory depth in 32-bit words
`define EXU_RAM_WORDS 256

// cycles from the first request cycle to the reply pulse
`define EXU_RAM_LAT 2

// mstatus after reset, MPP = machine mode
`define EXU_MSTATUS_RST 32'h0000_1800

`endif

// ==== rtl/exu_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exu_macros.svh"

module exu_alu (
  input  wire logic [`EXU_XLEN-1:0] src1_i,
  input  wire logic [`EXU_XLEN-1:0] src2_i,
  input  wire exu_pkg::alu_op_e     op_i,
  output logic      [`EXU_XLEN-1:0] res_o
);
  import exu_pkg::*;

  logic [4:0] shamt;

  assign shamt = src2_i[4:0];

  always_comb begin
    case (op_i)
      ADD: begin
        res_o = src1_i + src2_i;
      end
      SUB: begin
        res_o = src1_i - src2_i;
      end
      AND: begin
        res_o = src1_i & src2_i;
      end
      OR: begin
        res_o = src1_i | src2_i;
      end
      XOR: begin
        res_o = src1_i ^ src2_i;
      end
      SLL: begin
        res_o = src1_i << shamt;
      end
      SRL: begin
        res_o = src1_i >> shamt;
      end
      SRA: begin
        res_o = $unsigned($signed(src1_i) >>> shamt);
      end
      SLT: begin
        res_o = `EXU_XLEN'($signed(src1_i) < $signed(src2_i));
      end
      SLTU: begin
        res_o = `EXU_XLEN'(src1_i < src2_i);
      end
      // used by bge/bgeu with swapped operands
      SLE: begin
        res_o = `EXU_XLEN'($signed(src1_i) <= $signed(src2_i));
      end
      SLEU: begin
        res_o = `EXU_XLEN'(src1_i <= src2_i);
      end
      PASS2: begin
        res_o = src2_i;
      end
      default: begin
        res_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/exu_csr_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exu_macros.svh"

module exu_csr_file (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 csr_we_i,
  input  wire exu_pkg::csr_addr_e   csr_addr_i,
  input  wire logic [`EXU_XLEN-1:0] csr_wdata_i,
  input  wire logic                 trap_we_i,
  input  wire logic [`EXU_XLEN-1:0] trap_pc_i,
  input  wire logic                 mret_we_i,
  output logic      [`EXU_XLEN-1:0] csr_rdata_o,
  output logic      [`EXU_XLEN-1:0] mepc_o,
  output logic      [`EXU_XLEN-1:0] mtvec_o
);
  import exu_pkg::*;

  // mstatus bit positions
  localparam int MIE_BIT  = 3;
  localparam int MPIE_BIT = 7;

  // environment call from M-mode
  localparam logic [`EXU_XLEN-1:0] CAUSE_ECALL_M = `EXU_XLEN'(11);

  logic [`EXU_XLEN-1:0] mstatus_q;
  logic [`EXU_XLEN-1:0] mepc_q;
  logic [`EXU_XLEN-1:0] mcause_q;
  logic [`EXU_XLEN-1:0] mtvec_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= `EXU_MSTATUS_RST;
      mepc_q    <= '0;
      mcause_q  <= '0;
      mtvec_q   <= '0;
    end else if (trap_we_i) begin
      mepc_q              <= trap_pc_i;
      mcause_q            <= CAUSE_ECALL_M;
      mstatus_q[MPIE_BIT] <= mstatus_q[MIE_BIT];
      mstatus_q[MIE_BIT]  <= 1'b0;
    end else if (mret_we_i) begin
      mstatus_q[MIE_BIT]  <= mstatus_q[MPIE_BIT];
      mstatus_q[MPIE_BIT] <= 1'b1;
    end else if (csr_we_i) begin
      case (csr_addr_i)
        CSR_MSTATUS: mstatus_q <= csr_wdata_i;
        CSR_MTVEC:   mtvec_q   <= csr_wdata_i;
        CSR_MEPC:    mepc_q    <= csr_wdata_i;
        CSR_MCAUSE:  mcause_q  <= csr_wdata_i;
        // unimplemented address, write dropped
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    case (csr_addr_i)
      CSR_MSTATUS: csr_rdata_o = mstatus_q;
      CSR_MTVEC:   csr_rdata_o = mtvec_q;
      CSR_MEPC:    csr_rdata_o = mepc_q;
      CSR_MCAUSE:  csr_rdata_o = mcause_q;
      default:     csr_rdata_o = '0;
    endcase
  end

  assign mepc_o  = mepc_q;
  assign mtvec_o = mtvec_q;

endmodule

`default_nettype wire

// ==== rtl/exu_data_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exu_macros.svh"

module exu_data_ram (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 req_i,
  input  wire logic                 we_i,
  input  wire logic [`EXU_XLEN-1:0] addr_i,
  input  wire logic [`EXU_XLEN-1:0] wdata_i,
  output logic                      rvalid_o,
  output logic      [`EXU_XLEN-1:0] rdata_o,
  output logic                      wready_o
);
  localparam int AW = $clog2(`EXU_RAM_WORDS);
  localparam int CW = $clog2(`EXU_RAM_LAT + 1);

  logic [`EXU_XLEN-1:0]     mem [`EXU_RAM_WORDS];
  // words that hold a stored value, the rest read as zero
  logic [`EXU_RAM_WORDS-1:0] written_q;
  logic                      active_q;
  logic [CW-1:0]             cnt_q;
  logic [AW-1:0]             idx;
  logic                      fire;

  assign idx  = addr_i[AW+1:2];
  assign fire = active_q & (cnt_q == CW'(1));

  always_ff @(posedge clk) begin
    if (rst) begin
      active_q  <= 1'b0;
      cnt_q     <= '0;
      rvalid_o  <= 1'b0;
      wready_o  <= 1'b0;
      written_q <= '0;
    end else begin
      rvalid_o <= 1'b0;
      wready_o <= 1'b0;
      if (fire) begin
        active_q <= 1'b0;
        if (we_i) begin
          wready_o       <= 1'b1;
          written_q[idx] <= 1'b1;
        end else begin
          rvalid_o <= 1'b1;
        end
      end else if (active_q) begin
        cnt_q <= cnt_q - CW'(1);
      end else if (req_i & ~rvalid_o & ~wready_o) begin
        // request still high while its reply is out, not a new one
        active_q <= 1'b1;
        cnt_q    <= CW'(`EXU_RAM_LAT - 1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      if (we_i) begin
        mem[idx] <= wdata_i;
      end else begin
        rdata_o <= written_q[idx] ? mem[idx] : '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OP_ALU    = 7'b0110011,
    OP_ALUI   = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ADD   = 4'd0,
    SUB   = 4'd1,
    AND   = 4'd2,
    OR    = 4'd3,
    XOR   = 4'd4,
    SLL   = 4'd5,
    SRL   = 4'd6,
    SRA   = 4'd7,
    SLT   = 4'd8,
    SLTU  = 4'd9,
    SLE   = 4'd10,
    SLEU  = 4'd11,
    PASS2 = 4'd12
  } alu_op_e;

  // funct3 of system instructions
  typedef enum logic [2:0] {
    PRIV   = 3'b000,
    CSRRW  = 3'b001,
    CSRRS  = 3'b010,
    CSRRC  = 3'b011,
    CSRRWI = 3'b101,
    CSRRSI = 3'b110,
    CSRRCI = 3'b111
  } sys_funct_e;

  typedef enum logic [11:0] {
    CSR_MSTATUS = 12'h300,
    CSR_MTVEC   = 12'h305,
    CSR_MEPC    = 12'h341,
    CSR_MCAUSE  = 12'h342
  } csr_addr_e;

  // imm field of the privileged forms
  localparam logic [11:0] PRIV_ECALL = 12'h000;
  localparam logic [11:0] PRIV_MRET  = 12'h302;

endpackage

`default_nettype wire

// ==== rtl/exu_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exu_macros.svh"

module exu_stage (
  input  wire logic                 clk,
  input  wire logic                 rst,
  // decoded operation
  input  wire logic [31:0]          inst_i,
  input  wire logic [`EXU_XLEN-1:0] pc_i,
  input  wire logic [`EXU_XLEN-1:0] imm_i,
  input  wire logic [`EXU_XLEN-1:0] op1_i,
  input  wire logic [`EXU_XLEN-1:0] op2_i,
  input  wire logic [`EXU_XLEN-1:0] opj_i,
  input  wire exu_pkg::alu_op_e     alu_op_i,
  input  wire logic [3:0]           rd_i,
  input  wire logic                 ren_i,
  input  wire logic                 wen_i,
  input  wire logic                 system_i,
  input  wire logic                 csr_wen_i,
  input  wire logic                 prev_valid_i,
  output logic                      ready_o,
  // writeback side
  output logic                      valid_o,
  input  wire logic                 next_ready_i,
  output logic      [3:0]           rd_o,
  output logic      [`EXU_XLEN-1:0] reg_wdata_o,
  output logic      [`EXU_XLEN-1:0] npc_o,
  output logic                      redirect_o,
  // data memory
  output logic                      mem_req_o,
  output logic                      mem_we_o,
  output logic      [`EXU_XLEN-1:0] mem_addr_o,
  output logic      [`EXU_XLEN-1:0] mem_wdata_o,
  input  wire logic                 mem_rvalid_i,
  input  wire logic [`EXU_XLEN-1:0] mem_rdata_i,
  input  wire logic                 mem_wready_i,
  // csr file
  output logic                      csr_we_o,
  output exu_pkg::csr_addr_e        csr_addr_o,
  output logic      [`EXU_XLEN-1:0] csr_wdata_o,
  output logic                      trap_we_o,
  output logic      [`EXU_XLEN-1:0] trap_pc_o,
  output logic                      mret_we_o,
  input  wire logic [`EXU_XLEN-1:0] csr_rdata_i,
  input  wire logic [`EXU_XLEN-1:0] mepc_i,
  input  wire logic [`EXU_XLEN-1:0] mtvec_i
);
  import exu_pkg::*;

  typedef enum logic {
    MEM_IDLE,
    MEM_BUSY
  } mem_state_e;

  mem_state_e           mem_state_q;
  logic                 accept;
  logic                 retire;
  logic                 mem_done;

  // captured operation
  logic [31:0]          inst_q;
  logic [`EXU_XLEN-1:0] pc_q;
  logic [`EXU_XLEN-1:0] imm_q;
  logic [`EXU_XLEN-1:0] src1_q;
  logic [`EXU_XLEN-1:0] src2_q;
  logic [`EXU_XLEN-1:0] opj_q;
  alu_op_e              alu_op_q;
  logic                 ren_q;
  logic                 wen_q;
  logic                 system_q;
  logic                 csr_wen_q;
  logic [`EXU_XLEN-1:0] load_q;

  opcode_e              opcode;
  sys_funct_e           funct;
  logic                 is_priv;
  logic                 is_ecall;
  logic                 is_mret;
  logic [`EXU_XLEN-1:0] alu_res;
  logic [`EXU_XLEN-1:0] target;
  logic [`EXU_XLEN-1:0] result;
  logic                 take;

  assign accept   = prev_valid_i & ready_o;
  assign retire   = valid_o & next_ready_i;
  assign mem_done = (mem_state_q == MEM_BUSY) & (mem_rvalid_i | mem_wready_i);

  // a new op may enter as the current one leaves
  assign ready_o = (mem_state_q == MEM_IDLE) & (~valid_o | next_ready_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_o     <= 1'b0;
      mem_state_q <= MEM_IDLE;
    end else begin
      if (retire) begin
        valid_o <= 1'b0;
      end
      if (accept) begin
        if (ren_i | wen_i) begin
          mem_state_q <= MEM_BUSY;
        end else begin
          valid_o <= 1'b1;
        end
      end
      if (mem_done) begin
        mem_state_q <= MEM_IDLE;
        valid_o     <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q    <= inst_i;
      pc_q      <= pc_i;
      imm_q     <= imm_i;
      src1_q    <= op1_i;
      src2_q    <= op2_i;
      opj_q     <= opj_i;
      alu_op_q  <= alu_op_i;
      rd_o      <= rd_i;
      ren_q     <= ren_i;
      wen_q     <= wen_i;
      system_q  <= system_i;
      csr_wen_q <= csr_wen_i;
    end
    if (mem_done & mem_rvalid_i) begin
      load_q <= mem_rdata_i;
    end
  end

  exu_alu u_alu (
    .src1_i (src1_q),
    .src2_i (src2_q),
    .op_i   (alu_op_q),
    .res_o  (alu_res)
  );

  assign opcode   = opcode_e'(inst_q[6:0]);
  assign funct    = sys_funct_e'(inst_q[14:12]);
  assign is_priv  = system_q & (funct == PRIV);
  assign is_ecall = is_priv & (imm_q[11:0] == PRIV_ECALL);
  assign is_mret  = is_priv & (imm_q[11:0] == PRIV_MRET);
  assign target   = opj_q + imm_q;

  // memory request, level until the reply
  assign mem_req_o   = (mem_state_q == MEM_BUSY);
  assign mem_we_o    = wen_q;
  assign mem_addr_o  = target;
  assign mem_wdata_o = src2_q;

  // csr side effects only on the retire handshake
  assign csr_addr_o = csr_addr_e'(imm_q[11:0]);
  assign csr_we_o   = retire & system_q & csr_wen_q & ~is_priv;
  assign trap_we_o  = retire & is_ecall;
  assign trap_pc_o  = pc_q;
  assign mret_we_o  = retire & is_mret;

  always_comb begin
    case (funct)
      CSRRW, CSRRWI: csr_wdata_o = src1_q;
      CSRRS, CSRRSI: csr_wdata_o = csr_rdata_i | src1_q;
      CSRRC, CSRRCI: csr_wdata_o = csr_rdata_i & ~src1_q;
      default:       csr_wdata_o = csr_rdata_i;
    endcase
  end

  always_comb begin
    if (ren_q) begin
      result = load_q;
    end else if (system_q) begin
      result = csr_rdata_i;
    end else if ((opcode == OP_JAL) || (opcode == OP_JALR)) begin
      result = pc_q + `EXU_XLEN'(4);
    end else begin
      result = alu_res;
    end
  end

  // x0 never takes a value
  assign reg_wdata_o = (rd_o == 4'd0) ? '0 : result;

  always_comb begin
    case (opcode)
      OP_JAL, OP_JALR: begin
        take = 1'b1;
      end
      OP_BRANCH: begin
        case (alu_op_q)
          SUB:                         take = ~|alu_res;
          XOR, SLT, SLTU, SLE, SLEU: take = |alu_res;
          default:                     take = 1'b0;
        endcase
      end
      OP_SYSTEM: begin
        take = is_ecall | is_mret;
      end
      default: begin
        take = 1'b0;
      end
    endcase
  end

  assign redirect_o = valid_o & take;
  assign npc_o      = is_ecall ? mtvec_i : (is_mret ? mepc_i : target);

endmodule

`default_nettype wire

// ==== rtl/exu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exu_macros.svh"

module exu_top (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic [31:0]          inst_i,
  input  wire logic [`EXU_XLEN-1:0] pc_i,
  input  wire logic [`EXU_XLEN-1:0] imm_i,
  input  wire logic [`EXU_XLEN-1:0] op1_i,
  input  wire logic [`EXU_XLEN-1:0] op2_i,
  input  wire logic [`EXU_XLEN-1:0] opj_i,
  input  wire exu_pkg::alu_op_e     alu_op_i,
  input  wire logic [3:0]           rd_i,
  input  wire logic                 ren_i,
  input  wire logic                 wen_i,
  input  wire logic                 system_i,
  input  wire logic                 csr_wen_i,
  input  wire logic                 prev_valid_i,
  output logic                      ready_o,
  output logic                      valid_o,
  input  wire logic                 next_ready_i,
  output logic      [3:0]           rd_o,
  output logic      [`EXU_XLEN-1:0] reg_wdata_o,
  output logic      [`EXU_XLEN-1:0] npc_o,
  output logic                      redirect_o
);
  import exu_pkg::*;

  logic                 mem_req;
  logic                 mem_we;
  logic [`EXU_XLEN-1:0] mem_addr;
  logic [`EXU_XLEN-1:0] mem_wdata;
  logic                 mem_rvalid;
  logic [`EXU_XLEN-1:0] mem_rdata;
  logic                 mem_wready;

  logic                 csr_we;
  csr_addr_e            csr_addr;
  logic [`EXU_XLEN-1:0] csr_wdata;
  logic                 trap_we;
  logic [`EXU_XLEN-1:0] trap_pc;
  logic                 mret_we;
  logic [`EXU_XLEN-1:0] csr_rdata;
  logic [`EXU_XLEN-1:0] mepc;
  logic [`EXU_XLEN-1:0] mtvec;

  exu_stage u_stage (
    .clk          (clk),
    .rst          (rst),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .imm_i        (imm_i),
    .op1_i        (op1_i),
    .op2_i        (op2_i),
    .opj_i        (opj_i),
    .alu_op_i     (alu_op_i),
    .rd_i         (rd_i),
    .ren_i        (ren_i),
    .wen_i        (wen_i),
    .system_i     (system_i),
    .csr_wen_i    (csr_wen_i),
    .prev_valid_i (prev_valid_i),
    .ready_o      (ready_o),
    .valid_o      (valid_o),
    .next_ready_i (next_ready_i),
    .rd_o         (rd_o),
    .reg_wdata_o  (reg_wdata_o),
    .npc_o        (npc_o),
    .redirect_o   (redirect_o),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata),
    .mem_wready_i (mem_wready),
    .csr_we_o     (csr_we),
    .csr_addr_o   (csr_addr),
    .csr_wdata_o  (csr_wdata),
    .trap_we_o    (trap_we),
    .trap_pc_o    (trap_pc),
    .mret_we_o    (mret_we),
    .csr_rdata_i  (csr_rdata),
    .mepc_i       (mepc),
    .mtvec_i      (mtvec)
  );

  exu_csr_file u_csr_file (
    .clk         (clk),
    .rst         (rst),
    .csr_we_i    (csr_we),
    .csr_addr_i  (csr_addr),
    .csr_wdata_i (csr_wdata),
    .trap_we_i   (trap_we),
    .trap_pc_i   (trap_pc),
    .mret_we_i   (mret_we),
    .csr_rdata_o (csr_rdata),
    .mepc_o      (mepc),
    .mtvec_o     (mtvec)
  );

  // responder model standing in for the data bus
  exu_data_ram u_data_ram (
    .clk      (clk),
    .rst      (rst),
    .req_i    (mem_req),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .rvalid_o (mem_rvalid),
    .rdata_o  (mem_rdata),
    .wready_o (mem_wready)
  );

endmodule

`default_nettype wire
